// File: src.f
+incdir+common
common/memtest_pkg.sv
hw/run_control.sv
hw/req_gen.sv
hw/checker/tag_shadow.sv
hw/checker/resp_checker.sv
hw/memtest_top.sv
tests/memtest_sva.sv
tests/memtest_tb.sv

// File: Bender.yml
package:
  name: memtest

sources:
  - include_dirs:
      - common
    files:
      - common/memtest_pkg.sv
      - hw/run_control.sv
      - hw/req_gen.sv
      - hw/checker/tag_shadow.sv
      - hw/checker/resp_checker.sv
      - hw/memtest_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/memtest_sva.sv
      - tests/memtest_tb.sv

// File: tests/memtest_tb.sv
/*
 * Memory exerciser testbench
 * Random runs against an in-order memory model with random latency,
 * status code and response count checks, one run with a corrupted read
 */
`timescale 1ns/1ns
`default_nettype none
`include "memtest_config.svh"

module memtest_tb;
    import memtest_pkg::*;

    localparam int NUM_RUNS = 4;
    // Offset bits that may be set: high field 17..12, low field 6..0
    localparam logic [31:0] OFFSET_MASK = 32'h0003_F07F;

    logic clk;
    logic reset;
    logic start;
    run_cfg_t cfg;
    rd_req_t rd_req;
    wr_req_t wr_req;
    rd_rsp_t rd_rsp;
    logic [`MT_CYCLES_W-1:0] rsp_count;

    logic [31:0] lfsr = 32'h16ad_dce0;
    logic [63:0] mem_model [logic [31:0]];
    // Pending responses, oldest first
    logic [63:0] rsp_line_q [$];
    int rsp_due_q [$];

    int cyc = 0;
    int last_due = -1;
    int rd_seen = 0;
    int wr_seen = 0;
    int status_count = 0;
    logic [63:0] status_code = '0;
    int corrupt_at = 0;
    int watch_cycles = 0;
    int run_len [NUM_RUNS];
    logic [31:0] base;

    memtest_top UUT
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .cfg       (cfg),
        .rd_req    (rd_req),
        .wr_req    (wr_req),
        .rd_rsp    (rd_rsp),
        .rsp_count (rsp_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Unwritten lines read as zero
    function automatic logic [63:0] read_line(input logic [31:0] addr);
        if (mem_model.exists(addr))
            return mem_model[addr];
        return '0;
    endfunction

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - cfg.mem_base;
        check_value(name, offset & ~OFFSET_MASK, '0);
    endtask

    // ==============================
    // Memory model
    // ==============================

    always @(posedge clk)
    begin
        logic [63:0] line;
        int due;
        cyc = cyc + 1;
        rd_rsp.valid <= 1'b0;
        if (!reset)
        begin
            // Writes land before a read in the same cycle
            if (wr_req.valid && (wr_req.addr == cfg.status_addr))
            begin
                status_count = status_count + 1;
                status_code = wr_req.data;
            end
            else if (wr_req.valid)
            begin
                check_addr("wr_req.addr offset", wr_req.addr);
                mem_model[wr_req.addr] = wr_req.data;
                wr_seen = wr_seen + 1;
            end
            if (rd_req.valid)
            begin
                check_addr("rd_req.addr offset", rd_req.addr);
                rd_seen = rd_seen + 1;
                line = read_line(rd_req.addr);
                // Bit 0 of byte 0 is a tag bit
                if (rd_seen == corrupt_at)
                    line[0] = ~line[0];
                // Latency 1..8, kept in order behind the previous response
                due = cyc + int'(rand_bits(3));
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                rsp_line_q.push_back(line);
                rsp_due_q.push_back(due);
            end
            if ((rsp_due_q.size() > 0) && (rsp_due_q[0] == cyc))
            begin
                line = rsp_line_q.pop_front();
                void'(rsp_due_q.pop_front());
                rd_rsp.valid <= 1'b1;
                rd_rsp.data <= line;
            end
        end
    end

    // ==============================
    // Runs
    // ==============================

    task automatic run_once(input int n, input int bad_read, input int exp_code);
        int waited;
        rd_seen = 0;
        wr_seen = 0;
        status_count = 0;
        corrupt_at = bad_read;
        @(posedge clk);
        cfg.cycles <= `MT_CYCLES_W'(n);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        check_value("rsp_count", rsp_count, 0);
        waited = 0;
        while (status_count == 0)
        begin
            if (waited > n + 60)
            begin
                $display("No status write arrived within %0d cycles of start", waited);
                stop_on_failure();
            end
            @(posedge clk);
            waited = waited + 1;
        end
        // Let any stray request show up before counting
        repeat (12) @(posedge clk);
        check_value("wr_req status count", status_count, 1);
        check_value("wr_req.data status", status_code, exp_code);
        check_value("rsp_count", rsp_count, rd_seen);
        if (bad_read == 0)
        begin
            check_value("rd_req.valid count", rd_seen, n);
            check_value("wr_req.valid count", wr_seen, n);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        cfg = '0;
        rd_rsp = '0;
        base = rand_bits(32);
        for (int i = 0; i < NUM_RUNS; i++)
        begin
            run_len[i] = 4 + int'(rand_bits(6));
            watch_cycles = watch_cycles + run_len[i] + 150;
        end
        watch_cycles = watch_cycles + 100;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // Status address well outside the mapped span
        cfg.mem_base <= base;
        cfg.status_addr <= base ^ 32'h8000_0000;
        repeat (5) @(posedge clk);
        check_value("rd_req.valid before start", rd_seen, 0);
        check_value("wr_req.valid before start", wr_seen + status_count, 0);

        run_once(run_len[0], 0, `MT_STATUS_PASS);
        run_once(run_len[1], 0, `MT_STATUS_PASS);
        run_once(run_len[2], 1 + int'(rand_bits(2)), `MT_STATUS_FAIL);
        run_once(run_len[3], 0, `MT_STATUS_PASS);

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Watchdog sized from the drawn run lengths
    initial
    begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test stalled", watch_cycles);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// File: tests/memtest_sva.sv
/*
 * Exerciser protocol assertions
 * Expected-tag FIFO bounds and no status pulse while reads still issue
 */
`timescale 1ns/1ns
`default_nettype none
`include "memtest_config.svh"

module memtest_sva
(
    input wire                               clk,
    input wire                               reset,
    input wire                               rd_valid,
    input wire                               status_go,
    input wire                               fifo_push,
    input wire                               fifo_pop,
    input wire [$clog2(`MT_FIFO_DEPTH):0]    fifo_count
);

    // Full FIFO must not take a push without a pop
    fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
        !(fifo_push && !fifo_pop && (fifo_count == `MT_FIFO_DEPTH)))
        else $error("expected-tag FIFO pushed while full");

    fifo_count_bound: assert property (@(posedge clk) disable iff (reset)
        fifo_count <= `MT_FIFO_DEPTH)
        else $error("expected-tag FIFO count above depth");

    // A pulse in RUN shows up as a read request beside or right after it
    status_not_in_run: assert property (@(posedge clk) disable iff (reset)
        status_go |-> (!rd_valid ##1 !rd_valid))
        else $error("status pulse while read requests still issue");

endmodule

bind memtest_top memtest_sva u_sva
(
    .clk        (clk),
    .reset      (reset),
    .rd_valid   (rd_req.valid),
    .status_go  (status_go),
    .fifo_push  (u_resp_checker.fifo_push),
    .fifo_pop   (u_resp_checker.fifo_pop),
    .fifo_count (u_resp_checker.fifo_count)
);

`default_nettype wire

// File: hw/memtest_top.sv
/*
 * Random memory exerciser
 * Three stage pipeline: run control, request generation, then the
 * shadow tag RAM and the response checker
 */
`timescale 1ns/1ns
`default_nettype none
`include "memtest_config.svh"

module memtest_top
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      start,
    input  wire memtest_pkg::run_cfg_t cfg,
    output memtest_pkg::rd_req_t     rd_req,
    output memtest_pkg::wr_req_t     wr_req,
    input  wire memtest_pkg::rd_rsp_t  rd_rsp,
    output logic [`MT_CYCLES_W-1:0]  rsp_count
);
    import memtest_pkg::*;

    // Control to request generator
    logic issue;
    logic status_go;
    logic status_fail;

    // Request generator to shadow RAM
    rand_idx_u wr_idx;
    rand_idx_u rd_idx;
    tag_t wr_tag;

    // Shadow RAM to checker
    logic exp_valid;
    tag_t exp_tag;

    // Checker back to control
    logic error;
    logic pending;

    run_control u_run_control
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .cfg_cycles  (cfg.cycles),
        .error       (error),
        .pending     (pending),
        .issue       (issue),
        .status_go   (status_go),
        .status_fail (status_fail)
    );

    // Host holds base and status address steady through a run
    req_gen u_req_gen
    (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .status_go   (status_go),
        .status_fail (status_fail),
        .mem_base    (cfg.mem_base),
        .status_addr (cfg.status_addr),
        .rd_req      (rd_req),
        .wr_req      (wr_req),
        .wr_idx      (wr_idx),
        .rd_idx      (rd_idx),
        .wr_tag      (wr_tag)
    );

    tag_shadow u_tag_shadow
    (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_req.valid),
        .wr_idx    (wr_idx),
        .wr_tag    (wr_tag),
        .rd_en     (rd_req.valid),
        .rd_idx    (rd_idx),
        .exp_valid (exp_valid),
        .exp_tag   (exp_tag)
    );

    resp_checker u_resp_checker
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .exp_valid (exp_valid),
        .exp_tag   (exp_tag),
        .rd_rsp    (rd_rsp),
        .error     (error),
        .pending   (pending),
        .rsp_count (rsp_count)
    );

endmodule

`default_nettype wire

// File: hw/checker/resp_checker.sv
/*
 * Response checker
 * Queues expected tags, compares each read response in order,
 * latches the first mismatch and counts checked responses
 */
`timescale 1ns/1ns
`default_nettype none
`include "memtest_config.svh"

module resp_checker
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire                        exp_valid,
    input  wire memtest_pkg::tag_t     exp_tag,
    input  wire memtest_pkg::rd_rsp_t  rd_rsp,
    output logic                       error,
    output logic                       pending,
    output logic [`MT_CYCLES_W-1:0]    rsp_count
);
    import memtest_pkg::*;

    localparam int PTR_W = $clog2(`MT_FIFO_DEPTH);

    // ==============================
    // Expected-tag FIFO
    // ==============================

    tag_t fifo_mem [`MT_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] fifo_count;
    logic fifo_empty;
    logic fifo_push;
    logic fifo_pop;
    logic bypass;
    tag_t expected;
    logic mismatch;

    assign fifo_empty = (fifo_count == '0);
    // Latency-1 response lands with its own expected tag
    assign bypass = rd_rsp.valid && fifo_empty;
    assign fifo_pop = rd_rsp.valid && !fifo_empty;
    assign fifo_push = exp_valid && !bypass;
    assign expected = fifo_empty ? exp_tag : fifo_mem[rd_ptr];
    assign mismatch = rd_rsp.valid && (line_to_tag(rd_rsp.data) != expected);

    // A tag on its way in still counts as outstanding
    assign pending = !fifo_empty || exp_valid;

    always_ff @(posedge clk)
    begin
        if (fifo_push)
            fifo_mem[wr_ptr] <= exp_tag;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
        end
        else
        begin
            if (fifo_push)
                wr_ptr <= (wr_ptr == PTR_W'(`MT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (fifo_pop)
                rd_ptr <= (rd_ptr == PTR_W'(`MT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            fifo_count <= fifo_count + fifo_push - fifo_pop;
        end
    end

    // ==============================
    // Error latch and counter
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            error <= 1'b0;
            rsp_count <= '0;
        end
        else
        begin
            if (mismatch)
                error <= 1'b1;
            if (rd_rsp.valid)
                rsp_count <= rsp_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/checker/tag_shadow.sv
/*
 * Shadow tag RAM
 * One tag per random index, write-first read with one cycle latency
 */
`timescale 1ns/1ns
`default_nettype none
`include "memtest_config.svh"

module tag_shadow
(
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          wr_en,
    input  wire memtest_pkg::rand_idx_u  wr_idx,
    input  wire memtest_pkg::tag_t       wr_tag,
    input  wire                          rd_en,
    input  wire memtest_pkg::rand_idx_u  rd_idx,
    output logic                         exp_valid,
    output memtest_pkg::tag_t            exp_tag
);
    import memtest_pkg::*;

    localparam int N_ENTRIES = 1 << `MT_RAND_BITS;

    tag_t mem [N_ENTRIES];

    // Memory under test starts zeroed, so the shadow does too
    initial
    begin
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_idx.flat] <= wr_tag;
        end
        // Same-cycle write to the read index wins
        exp_tag <= (wr_en && (wr_idx.flat == rd_idx.flat)) ? wr_tag : mem[rd_idx.flat];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            exp_valid <= 1'b0;
        else
            exp_valid <= rd_en;
    end

endmodule

`default_nettype wire

// File: hw/req_gen.sv
/*
 * Request generator
 * Free-running LFSRs pick read and write lines and write data,
 * one read and one write per issue cycle, plus the final status write
 */
`timescale 1ns/1ns
`default_nettype none
`include "memtest_config.svh"

module req_gen
(
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          issue,
    input  wire                          status_go,
    input  wire                          status_fail,
    input  wire [`MT_LINE_ADDR_W-1:0]    mem_base,
    input  wire [`MT_LINE_ADDR_W-1:0]    status_addr,
    output memtest_pkg::rd_req_t         rd_req,
    output memtest_pkg::wr_req_t         wr_req,
    output memtest_pkg::rand_idx_u       wr_idx,
    output memtest_pkg::rand_idx_u       rd_idx,
    output memtest_pkg::tag_t            wr_tag
);
    import memtest_pkg::*;

    localparam int GAP_BITS = `MT_ADDR_BITS - `MT_RAND_BITS;
    localparam logic [31:0] RD_SEED = 32'h0000_2721;
    localparam logic [31:0] WR_SEED = 32'h0000_8520;

    // ==============================
    // Address mapping
    // ==============================

    // High field above a zero gap, low field at the bottom
    function automatic logic [`MT_LINE_ADDR_W-1:0] map_addr(
        input logic [`MT_LINE_ADDR_W-1:0] base,
        input rand_idx_u idx
    );
        return base + `MT_LINE_ADDR_W'({idx.f.high, GAP_BITS'(0), idx.f.low});
    endfunction

    logic [31:0] rd_lfsr;
    logic [31:0] wr_lfsr;
    // Two data words make up one line
    logic [1:0][31:0] dat_lfsr;

    rand_idx_u rd_next_idx;
    rand_idx_u wr_next_idx;
    logic [`MT_DATA_W-1:0] wr_next_data;

    assign rd_next_idx = rand_idx_u'(rd_lfsr[`MT_RAND_BITS-1:0]);
    assign wr_next_idx = rand_idx_u'(wr_lfsr[`MT_RAND_BITS-1:0]);
    assign wr_next_data = dat_lfsr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_lfsr <= RD_SEED;
            wr_lfsr <= WR_SEED;
            dat_lfsr[0] <= 32'h1;
            dat_lfsr[1] <= 32'h2;
        end
        else
        begin
            rd_lfsr <= lfsr_next(rd_lfsr);
            wr_lfsr <= lfsr_next(wr_lfsr);
            dat_lfsr[0] <= lfsr_next(dat_lfsr[0]);
            dat_lfsr[1] <= lfsr_next(dat_lfsr[1]);
        end
    end

    // ==============================
    // Registered requests
    // ==============================

    always_ff @(posedge clk)
    begin
        rd_req.valid <= issue;
        rd_req.addr <= map_addr(mem_base, rd_next_idx);
        rd_idx <= rd_next_idx;

        wr_req.valid <= issue;
        wr_req.addr <= map_addr(mem_base, wr_next_idx);
        wr_req.data <= wr_next_data;

        // Status write replaces the data write, never during RUN
        if (status_go)
        begin
            wr_req.valid <= 1'b1;
            wr_req.addr <= status_addr;
            wr_req.data <= status_fail ? `MT_DATA_W'(`MT_STATUS_FAIL)
                                       : `MT_DATA_W'(`MT_STATUS_PASS);
        end

        if (reset)
        begin
            rd_req.valid <= 1'b0;
            wr_req.valid <= 1'b0;
        end
    end

    // Shadow update only moves on data writes; the status write
    // rewrites the last data tag, which leaves the shadow unchanged
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_idx <= '0;
            wr_tag <= '0;
        end
        else if (issue)
        begin
            wr_idx <= wr_next_idx;
            wr_tag <= line_to_tag(wr_next_data);
        end
    end

endmodule

`default_nettype wire

// File: hw/run_control.sv
/*
 * Run control FSM
 * Counts down the configured cycles in RUN, drains outstanding
 * reads, then fires a single status pulse with the fail flag
 */
`timescale 1ns/1ns
`default_nettype none
`include "memtest_config.svh"

module run_control
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire [`MT_CYCLES_W-1:0]  cfg_cycles,
    input  wire                     error,
    input  wire                     pending,
    output logic                    issue,
    output logic                    status_go,
    output logic                    status_fail
);
    import memtest_pkg::*;

    // Last read reaches the checker FIFO two cycles after its issue slot
    localparam int DRAIN_SETTLE = 1;

    run_state_e state;
    // Remaining cycles in RUN, settle count in DRAIN
    logic [`MT_CYCLES_W-1:0] cnt;

    assign issue = (state == RUN);
    assign status_go = (state == DRAIN) && (cnt == '0) && !pending;
    assign status_fail = error;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    // Zero-length run goes straight to the status write
                    if (start)
                    begin
                        cnt <= cfg_cycles;
                        state <= (cfg_cycles == '0) ? DRAIN : RUN;
                    end
                end
                RUN:
                begin
                    cnt <= cnt - 1'b1;
                    if (error || (cnt == `MT_CYCLES_W'(1)))
                    begin
                        cnt <= `MT_CYCLES_W'(DRAIN_SETTLE);
                        state <= DRAIN;
                    end
                end
                DRAIN:
                begin
                    if (cnt != '0)
                    begin
                        cnt <= cnt - 1'b1;
                    end
                    else if (!pending)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: common/memtest_pkg.sv
/*
 * Memory exerciser types
 * Request, response and config words, the random index union,
 * the run states and the shared tag and LFSR functions
 */
`default_nettype none
`include "memtest_config.svh"

package memtest_pkg;

    typedef logic [`MT_TAG_W-1:0] tag_t;

    // Field view of the random index, used to build the line address
    typedef struct packed {
        logic [`MT_HIGH_BITS-1:0] high;
        logic [`MT_LOW_BITS-1:0] low;
    } rand_fields_t;

    // Flat view addresses the shadow RAM
    typedef union packed {
        logic [`MT_RAND_BITS-1:0] flat;
        rand_fields_t f;
    } rand_idx_u;

    typedef struct packed {
        logic valid;
        logic [`MT_LINE_ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic valid;
        logic [`MT_LINE_ADDR_W-1:0] addr;
        logic [`MT_DATA_W-1:0] data;
    } wr_req_t;

    typedef struct packed {
        logic valid;
        logic [`MT_DATA_W-1:0] data;
    } rd_rsp_t;

    typedef struct packed {
        logic [`MT_LINE_ADDR_W-1:0] mem_base;
        logic [`MT_LINE_ADDR_W-1:0] status_addr;
        logic [`MT_CYCLES_W-1:0] cycles;
    } run_cfg_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } run_state_e;

    // Low two bits of each byte, byte 7 ends up as the top pair
    function automatic tag_t line_to_tag(input logic [`MT_DATA_W-1:0] line);
        tag_t t;
        for (int i = 0; i < `MT_DATA_W / 8; i++)
        begin
            t[2*i +: 2] = line[8*i +: 2];
        end
        return t;
    endfunction

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] r);
        return {1'b0, r[31:1]} ^ (r[0] ? 32'h8020_0003 : 32'h0);
    endfunction

endpackage

`default_nettype wire

// File: common/memtest_config.svh
/*
 * Memory exerciser constants
 * Widths, random address mapping, checker FIFO depth and status codes
 */
`ifndef MEMTEST_CONFIG_SVH
`define MEMTEST_CONFIG_SVH

// Random index split between low bits and bits above the zero gap
`define MT_RAND_BITS 13
`define MT_LOW_BITS 7
`define MT_HIGH_BITS 6
// Span of the mapped offset, gap is the difference to MT_RAND_BITS
`define MT_ADDR_BITS 18

`define MT_LINE_ADDR_W 32
`define MT_DATA_W 64
`define MT_TAG_W 16
`define MT_CYCLES_W 24

`define MT_FIFO_DEPTH 16

`define MT_STATUS_PASS 1
`define MT_STATUS_FAIL 2

`endif
